// File: project.f
+incdir+.
axil_fifo_pkg.sv
axil_two_fifo.sv
axil_read_capture.sv
axil_write_capture.sv
axil_req_serializer.sv
fifo_scratch_mem.sv
axil_fifo_bridge.sv
tb_axil_fifo_bridge.sv

// File: run.sh
#!/usr/bin/env bash
# builds the bridge testbench with Verilator, runs it and looks for the pass line.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_axil_fifo_bridge \
  -f project.f

output=$(./obj_dir/Vtb_axil_fifo_bridge || true)
echo "$output"

if grep -qx "Done: no errors" <<< "$output"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

// File: tb_axil_fifo_bridge.sv
// testbench for the AXI4-Lite to fifo bridge; runs a table of writes and reads and checks each response.
`timescale 1ns/1ns

module tb_axil_fifo_bridge
  import axil_fifo_pkg::*;
();

  typedef enum {OP_WR, OP_RD, OP_RW} op_e;

  logic     clk;
  logic     rst_n_i;
  axil_aw_t aw_i;
  logic     awvalid_i;
  logic     awready_o;
  axil_w_t  w_i;
  logic     wvalid_i;
  logic     wready_o;
  axil_ar_t ar_i;
  logic     arvalid_i;
  logic     arready_o;
  axil_r_t  r_o;
  logic     rvalid_o;
  logic     rready_i;
  axil_b_t  b_o;
  logic     bvalid_o;
  logic     bready_i;

  integer seed = 32'h52fd_ae90;
  int     cycles = 0;

  // stimulus table, one column per queue.
  string       tbl_name [$];
  op_e         tbl_op [$];
  logic [31:0] tbl_addr [$];
  logic [31:0] tbl_wdata [$];
  logic [3:0]  tbl_strb [$];
  logic [31:0] tbl_exp [$];   // expected read data.
  logic        tbl_bp [$];    // random RREADY and BREADY.

  axil_fifo_bridge i_dut (
    .clk_i    (clk),
    .rst_n_i  (rst_n_i),
    .aw_i     (aw_i),
    .awvalid_i(awvalid_i),
    .awready_o(awready_o),
    .w_i      (w_i),
    .wvalid_i (wvalid_i),
    .wready_o (wready_o),
    .ar_i     (ar_i),
    .arvalid_i(arvalid_i),
    .arready_o(arready_o),
    .r_o      (r_o),
    .rvalid_o (rvalid_o),
    .rready_i (rready_i),
    .b_o      (b_o),
    .bvalid_o (bvalid_o),
    .bready_i (bready_i)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > 40 * tbl_name.size() + 100) begin
      $display("timeout: the bridge stopped answering before the table was done.");
      $display("Done: errors found");
      $fatal(1, "cycle limit reached.");
    end
  end

  task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Error %s: expected %h, actual %h", name, expected, actual);
      $display("Done: errors found");
      $fatal(1, "stopped at first mismatch.");
    end
  endtask

  task automatic add_test(input string name, input op_e op, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic [3:0] strb,
                          input logic [31:0] exp, input logic bp);
    tbl_name.push_back(name);
    tbl_op.push_back(op);
    tbl_addr.push_back(addr);
    tbl_wdata.push_back(wdata);
    tbl_strb.push_back(strb);
    tbl_exp.push_back(exp);
    tbl_bp.push_back(bp);
  endtask

  // AW and W go out together and each drops after its own handshake.
  task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input logic bp, output logic [1:0] bresp);
    logic        aw_pend;
    logic        w_pend;
    logic        aw_go;
    logic        w_go;
    logic [31:0] rnd;
    aw_i.addr = addr;
    aw_i.prot = 3'b000;
    w_i.data  = data;
    w_i.strb  = strb;
    awvalid_i = 1'b1;
    wvalid_i  = 1'b1;
    aw_pend   = 1'b1;
    w_pend    = 1'b1;
    while (aw_pend || w_pend) begin
      aw_go = aw_pend & awready_o;
      w_go  = w_pend & wready_o;
      @(negedge clk);
      if (aw_go) begin
        awvalid_i = 1'b0;
        aw_pend   = 1'b0;
      end
      if (w_go) begin
        wvalid_i = 1'b0;
        w_pend   = 1'b0;
      end
    end
    rnd = $random(seed);
    bready_i = bp ? rnd[0] : 1'b1;
    while (!(bvalid_o && bready_i)) begin
      @(negedge clk);
      rnd = $random(seed);
      bready_i = bp ? rnd[0] : 1'b1;
    end
    bresp = b_o.resp;   // taken at the next rising edge.
    @(negedge clk);
    bready_i = 1'b0;
  endtask

  task automatic read_word(input logic [31:0] addr, input logic bp,
                           output logic [31:0] rdata, output logic [1:0] rresp);
    logic        ar_go;
    logic [31:0] rnd;
    ar_i.addr = addr;
    ar_i.prot = 3'b000;
    arvalid_i = 1'b1;
    ar_go = 1'b0;
    while (!ar_go) begin
      ar_go = arready_o;
      @(negedge clk);
    end
    arvalid_i = 1'b0;
    rnd = $random(seed);
    rready_i = bp ? rnd[0] : 1'b1;
    while (!(rvalid_o && rready_i)) begin
      @(negedge clk);
      rnd = $random(seed);
      rready_i = bp ? rnd[0] : 1'b1;
    end
    rdata = r_o.data;
    rresp = r_o.resp;
    @(negedge clk);
    rready_i = 1'b0;
  endtask

  initial begin
    logic [1:0]  bresp;
    logic [1:0]  rresp;
    logic [31:0] rdata;
    rst_n_i   = 1'b0;
    aw_i      = '0;
    awvalid_i = 1'b0;
    w_i       = '0;
    wvalid_i  = 1'b0;
    ar_i      = '0;
    arvalid_i = 1'b0;
    rready_i  = 1'b0;
    bready_i  = 1'b0;

    // word 4 and its alias at 0x410 share storage.
    add_test("wr_full", OP_WR, 32'h0000_0010, 32'hdead_beef, 4'hf, 32'h0, 1'b0);
    add_test("rd_full", OP_RD, 32'h0000_0010, 32'h0, 4'h0, 32'hdead_beef, 1'b0);
    add_test("rd_alias", OP_RD, 32'h0000_0410, 32'h0, 4'h0, 32'hdead_beef, 1'b0);
    add_test("wr_alias", OP_WR, 32'h1000_0420, 32'h1234_5678, 4'hf, 32'h0, 1'b0);
    add_test("rd_alias_back", OP_RD, 32'h0000_0020, 32'h0, 4'h0, 32'h1234_5678, 1'b0);
    // partial strobes merge into the old word.
    add_test("wr_strb_lo", OP_WR, 32'h0000_0010, 32'h0000_aa55, 4'h3, 32'h0, 1'b0);
    add_test("rd_strb_lo", OP_RD, 32'h0000_0010, 32'h0, 4'h0, 32'hdead_aa55, 1'b0);
    add_test("wr_strb_hi", OP_WR, 32'h0000_0010, 32'h1100_0000, 4'h8, 32'h0, 1'b0);
    add_test("wr_strb_mid", OP_WR, 32'h0000_0010, 32'h0077_0000, 4'h4, 32'h0, 1'b0);
    add_test("rd_strb_all", OP_RD, 32'h0000_0010, 32'h0, 4'h0, 32'h1177_aa55, 1'b0);
    add_test("rd_unalign_3", OP_RD, 32'h0000_0013, 32'h0, 4'h0, 32'h1177_aa55, 1'b0);
    add_test("rd_unalign_2", OP_RD, 32'h0000_0022, 32'h0, 4'h0, 32'h1234_5678, 1'b0);
    // read and write in the same cycle, the read sees the old word.
    add_test("wr_rw_init", OP_WR, 32'h0000_0030, 32'hcafe_0001, 4'hf, 32'h0, 1'b0);
    add_test("rw_same", OP_RW, 32'h0000_0030, 32'hcafe_0002, 4'hf, 32'hcafe_0001, 1'b0);
    add_test("rd_rw_after", OP_RD, 32'h0000_0030, 32'h0, 4'h0, 32'hcafe_0002, 1'b0);
    // back-pressure phase.
    add_test("bp_wr_a", OP_WR, 32'h0000_0040, 32'h0bad_f00d, 4'hf, 32'h0, 1'b1);
    add_test("bp_rd_a", OP_RD, 32'h0000_0040, 32'h0, 4'h0, 32'h0bad_f00d, 1'b1);
    add_test("bp_wr_b", OP_WR, 32'h0000_0044, 32'ha5a5_a5a5, 4'hf, 32'h0, 1'b1);
    add_test("bp_wr_b_lo", OP_WR, 32'h0000_0044, 32'h0000_005a, 4'h1, 32'h0, 1'b1);
    add_test("bp_rd_b", OP_RD, 32'h0000_0044, 32'h0, 4'h0, 32'ha5a5_a55a, 1'b1);
    add_test("bp_rw_a", OP_RW, 32'h0000_0040, 32'h600d_cafe, 4'hf, 32'h0bad_f00d, 1'b1);
    add_test("bp_rd_a2", OP_RD, 32'h0000_0040, 32'h0, 4'h0, 32'h600d_cafe, 1'b1);
    add_test("bp_rd_old", OP_RD, 32'h0000_0010, 32'h0, 4'h0, 32'h1177_aa55, 1'b1);

    repeat (8) @(negedge clk);
    rst_n_i = 1'b1;
    @(negedge clk);
    check("reset_rvalid", 32'h0, 32'(rvalid_o));
    check("reset_bvalid", 32'h0, 32'(bvalid_o));
    check("reset_awready", 32'h1, 32'(awready_o));
    check("reset_wready", 32'h1, 32'(wready_o));
    check("reset_arready", 32'h1, 32'(arready_o));

    for (int i = 0; i < tbl_name.size(); i++) begin
      case (tbl_op[i])
        OP_WR: begin
          write_word(tbl_addr[i], tbl_wdata[i], tbl_strb[i], tbl_bp[i], bresp);
          check({tbl_name[i], " bresp"}, 32'(OKAY), 32'(bresp));
        end
        OP_RD: begin
          read_word(tbl_addr[i], tbl_bp[i], rdata, rresp);
          check({tbl_name[i], " rresp"}, 32'(OKAY), 32'(rresp));
          check({tbl_name[i], " rdata"}, tbl_exp[i], rdata);
        end
        default: begin
          fork
            write_word(tbl_addr[i], tbl_wdata[i], tbl_strb[i], tbl_bp[i], bresp);
            read_word(tbl_addr[i], tbl_bp[i], rdata, rresp);
          join
          check({tbl_name[i], " bresp"}, 32'(OKAY), 32'(bresp));
          check({tbl_name[i], " rresp"}, 32'(OKAY), 32'(rresp));
          check({tbl_name[i], " rdata"}, tbl_exp[i], rdata);
        end
      endcase
    end

    // idle bus, so a duplicate response would still be pending here.
    repeat (10) @(negedge clk);
    check("idle_rvalid", 32'h0, 32'(rvalid_o));
    check("idle_bvalid", 32'h0, 32'(bvalid_o));
    $display("Done: no errors");
    $finish;
  end

endmodule

// File: axil_fifo_bridge.sv
// top level of the AXI4-Lite subordinate bridge with its scratch memory behind the command stream.
`timescale 1ns/1ns
`include "axil_fifo_consts.svh"

module axil_fifo_bridge
  import axil_fifo_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  axil_aw_t aw_i,
  input  logic     awvalid_i,
  output logic     awready_o,
  input  axil_w_t  w_i,
  input  logic     wvalid_i,
  output logic     wready_o,
  input  axil_ar_t ar_i,
  input  logic     arvalid_i,
  output logic     arready_o,
  output axil_r_t  r_o,
  output logic     rvalid_o,
  input  logic     rready_i,
  output axil_b_t  b_o,
  output logic     bvalid_o,
  input  logic     bready_i
);

  rd_req_t                 rd_req;
  logic                    rd_valid;
  logic                    rd_yumi;
  wr_req_t                 wr_req;
  logic                    wr_valid;
  logic                    wr_yumi;
  fifo_cmd_t               cmd;
  logic                    cmd_valid;
  logic                    cmd_ready;
  logic [`AXIL_DATA_W-1:0] resp_data;
  logic                    resp_valid;
  logic                    resp_ready;

  axil_read_capture i_read_capture (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .ar_i      (ar_i),
    .arvalid_i (arvalid_i),
    .arready_o (arready_o),
    .rd_req_o  (rd_req),
    .rd_valid_o(rd_valid),
    .rd_yumi_i (rd_yumi)
  );

  axil_write_capture i_write_capture (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .aw_i      (aw_i),
    .awvalid_i (awvalid_i),
    .awready_o (awready_o),
    .w_i       (w_i),
    .wvalid_i  (wvalid_i),
    .wready_o  (wready_o),
    .wr_req_o  (wr_req),
    .wr_valid_o(wr_valid),
    .wr_yumi_i (wr_yumi)
  );

  axil_req_serializer i_serializer (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .rd_req_i    (rd_req),
    .rd_valid_i  (rd_valid),
    .rd_yumi_o   (rd_yumi),
    .wr_req_i    (wr_req),
    .wr_valid_i  (wr_valid),
    .wr_yumi_o   (wr_yumi),
    .cmd_o       (cmd),
    .cmd_valid_o (cmd_valid),
    .cmd_ready_i (cmd_ready),
    .resp_data_i (resp_data),
    .resp_valid_i(resp_valid),
    .resp_ready_o(resp_ready),
    .r_o         (r_o),
    .rvalid_o    (rvalid_o),
    .rready_i    (rready_i),
    .b_o         (b_o),
    .bvalid_o    (bvalid_o),
    .bready_i    (bready_i)
  );

  fifo_scratch_mem i_mem (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cmd_i       (cmd),
    .cmd_valid_i (cmd_valid),
    .cmd_ready_o (cmd_ready),
    .resp_data_o (resp_data),
    .resp_valid_o(resp_valid),
    .resp_ready_i(resp_ready)
  );

endmodule

// File: fifo_scratch_mem.sv
// byte-masked scratch word memory on the fifo command side, answering each command once.
`timescale 1ns/1ns
`include "axil_fifo_consts.svh"

module fifo_scratch_mem
  import axil_fifo_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  fifo_cmd_t               cmd_i,
  input  logic                    cmd_valid_i,
  output logic                    cmd_ready_o,
  output logic [`AXIL_DATA_W-1:0] resp_data_o,
  output logic                    resp_valid_o,
  input  logic                    resp_ready_i
);

  logic [`AXIL_DATA_W-1:0] mem [`MEM_WORDS];
  logic [`MEM_IDX_W-1:0]   idx;
  logic                    cmd_fire;

  // word index from the bits above the byte offset, upper bits wrap.
  assign idx = cmd_i.addr[`MEM_IDX_W+1:2];

  // a held response blocks new work unless it leaves this cycle.
  assign cmd_ready_o = ~resp_valid_o | resp_ready_i;
  assign cmd_fire    = cmd_valid_i & cmd_ready_o;

  always_ff @(posedge clk_i) begin
    if (cmd_fire && cmd_i.we) begin
      for (int b = 0; b < `AXIL_STRB_W; b++) begin
        if (cmd_i.mask[b]) begin
          mem[idx][8*b +: 8] <= cmd_i.data[8*b +: 8];
        end
      end
    end
  end

  // response payload.
  always_ff @(posedge clk_i) begin
    if (cmd_fire) begin
      resp_data_o <= cmd_i.we ? '0 : mem[idx];   // writes answer with zero.
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      resp_valid_o <= 1'b0;
    end else if (cmd_fire) begin
      resp_valid_o <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_o <= 1'b0;   // drained, nothing new.
    end
  end

endmodule

// File: axil_req_serializer.sv
// merges read and write requests into one command stream and steers in-order responses to R or B.
`timescale 1ns/1ns
`include "axil_fifo_consts.svh"

module axil_req_serializer
  import axil_fifo_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  rd_req_t                 rd_req_i,
  input  logic                    rd_valid_i,
  output logic                    rd_yumi_o,
  input  wr_req_t                 wr_req_i,
  input  logic                    wr_valid_i,
  output logic                    wr_yumi_o,
  output fifo_cmd_t               cmd_o,
  output logic                    cmd_valid_o,
  input  logic                    cmd_ready_i,
  input  logic [`AXIL_DATA_W-1:0] resp_data_i,
  input  logic                    resp_valid_i,
  output logic                    resp_ready_o,
  output axil_r_t                 r_o,
  output logic                    rvalid_o,
  input  logic                    rready_i,
  output axil_b_t                 b_o,
  output logic                    bvalid_o,
  input  logic                    bready_i
);

  logic rd_sel;
  logic cmd_fire;
  logic ret_ready;
  logic ret_we;
  logic ret_valid;
  logic resp_fire;

  assign rd_sel = rd_valid_i;   // reads win.

  always_comb begin
    cmd_o.addr = rd_sel ? rd_req_i.addr : wr_req_i.addr;
    cmd_o.we   = ~rd_sel;
    cmd_o.data = wr_req_i.data;
    cmd_o.mask = rd_sel ? '0 : wr_req_i.mask;
  end

  // no command leaves without a slot to remember its kind.
  assign cmd_valid_o = ret_ready & (rd_valid_i | wr_valid_i);
  assign cmd_fire    = cmd_valid_o & cmd_ready_i;

  assign rd_yumi_o = cmd_fire & rd_sel;
  assign wr_yumi_o = cmd_fire & ~rd_sel;

  // return-order record, one write flag per outstanding command.
  axil_two_fifo #(
    .payload_t(logic)
  ) i_ret_fifo (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .data_i (cmd_o.we),
    .valid_i(cmd_fire),
    .ready_o(ret_ready),
    .data_o (ret_we),
    .valid_o(ret_valid),
    .yumi_i (resp_fire)
  );

  // oldest flag picks the channel for the response now at the head.
  assign rvalid_o = resp_valid_i & ret_valid & ~ret_we;
  assign bvalid_o = resp_valid_i & ret_valid & ret_we;

  assign resp_ready_o = ret_valid & (ret_we ? bready_i : rready_i);
  assign resp_fire    = resp_valid_i & resp_ready_o;

  always_comb begin
    r_o.data = resp_data_i;
    r_o.resp = OKAY;
    b_o.resp = OKAY;
  end

  // the memory answers only commands that were recorded here.
  a_resp_has_tag: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) resp_valid_i |-> ret_valid
  ) else $error("memory response with no outstanding command.");

endmodule

// File: axil_write_capture.sv
// AW and W channel capture; joins an address with its data into one write request.
`timescale 1ns/1ns

module axil_write_capture
  import axil_fifo_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  axil_aw_t aw_i,
  input  logic     awvalid_i,
  output logic     awready_o,
  input  axil_w_t  w_i,
  input  logic     wvalid_i,
  output logic     wready_o,
  output wr_req_t  wr_req_o,
  output logic     wr_valid_o,
  input  logic     wr_yumi_i
);

  axil_aw_t aw_head;
  axil_w_t  w_head;
  logic     aw_valid;
  logic     w_valid;

  // each channel has its own buffer so either may arrive first.
  axil_two_fifo #(
    .payload_t(axil_aw_t)
  ) i_aw_fifo (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .data_i (aw_i),
    .valid_i(awvalid_i),
    .ready_o(awready_o),
    .data_o (aw_head),
    .valid_o(aw_valid),
    .yumi_i (wr_yumi_i)
  );

  axil_two_fifo #(
    .payload_t(axil_w_t)
  ) i_w_fifo (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .data_i (w_i),
    .valid_i(wvalid_i),
    .ready_o(wready_o),
    .data_o (w_head),
    .valid_o(w_valid),
    .yumi_i (wr_yumi_i)
  );

  // a write exists only once both halves are here.
  assign wr_valid_o = aw_valid & w_valid;

  always_comb begin
    wr_req_o.addr = aw_head.addr;   // prot dropped.
    wr_req_o.data = w_head.data;
    wr_req_o.mask = w_head.strb;
  end

  // both heads leave together, so the two buffers never drift apart.
  a_joined_pop: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) wr_yumi_i |-> (aw_valid && w_valid)
  ) else $error("write request taken before AW and W were both present.");

endmodule

// File: axil_read_capture.sv
// AR channel capture; buffers read addresses and hands word-aligned read requests onward.
`timescale 1ns/1ns
`include "axil_fifo_consts.svh"

module axil_read_capture
  import axil_fifo_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  axil_ar_t ar_i,
  input  logic     arvalid_i,
  output logic     arready_o,
  output rd_req_t  rd_req_o,
  output logic     rd_valid_o,
  input  logic     rd_yumi_i
);

  rd_req_t ar_req;

  // prot is not carried; the low two bits select a byte and are cleared.
  assign ar_req.addr = {ar_i.addr[`AXIL_ADDR_W-1:2], 2'b00};

  axil_two_fifo #(
    .payload_t(rd_req_t)
  ) i_ar_fifo (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .data_i (ar_req),
    .valid_i(arvalid_i),
    .ready_o(arready_o),
    .data_o (rd_req_o),
    .valid_o(rd_valid_o),
    .yumi_i (rd_yumi_i)
  );

endmodule

// File: axil_two_fifo.sv
// two-entry valid/ready buffer with a typed payload; pops are signalled by yumi.
`timescale 1ns/1ns

module axil_two_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  payload_t data_i,
  input  logic     valid_i,
  output logic     ready_o,
  output payload_t data_o,
  output logic     valid_o,
  input  logic     yumi_i
);

  payload_t   slots [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic       push;
  logic       pop;

  assign ready_o = (count != 2'd2);   // room for at least one more.
  assign valid_o = (count != 2'd0);
  assign data_o  = slots[rd_ptr];

  assign push = valid_i & ready_o;
  assign pop  = yumi_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      slots[wr_ptr] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) wr_ptr <= ~wr_ptr;
      if (pop) rd_ptr <= ~rd_ptr;
      // both at once leaves the count alone.
      case ({push, pop})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;
      endcase
    end
  end

  // the consumer may only take an entry that is actually held.
  a_no_yumi_when_empty: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) yumi_i |-> valid_o
  ) else $error("yumi asserted on an empty two-entry buffer.");

endmodule

// File: axil_fifo_pkg.sv
// channel, request and command types shared by every block of the AXI4-Lite to fifo bridge.
`include "axil_fifo_consts.svh"

package axil_fifo_pkg;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axil_resp_e;

  typedef struct packed {
    logic [`AXIL_ADDR_W-1:0] addr;
    logic [2:0]              prot;
  } axil_aw_t;

  typedef struct packed {
    logic [`AXIL_DATA_W-1:0] data;
    logic [`AXIL_STRB_W-1:0] strb;
  } axil_w_t;

  typedef struct packed {
    logic [`AXIL_ADDR_W-1:0] addr;
    logic [2:0]              prot;
  } axil_ar_t;

  typedef struct packed {
    logic [`AXIL_DATA_W-1:0] data;
    axil_resp_e              resp;
  } axil_r_t;

  typedef struct packed {
    axil_resp_e resp;
  } axil_b_t;

  // one serialized access to the memory side.
  typedef struct packed {
    logic [`AXIL_ADDR_W-1:0] addr;
    logic                    we;   // 1 for a write.
    logic [`AXIL_DATA_W-1:0] data;
    logic [`AXIL_STRB_W-1:0] mask;
  } fifo_cmd_t;

  typedef struct packed {
    logic [`AXIL_ADDR_W-1:0] addr;  // already word aligned.
  } rd_req_t;

  typedef struct packed {
    logic [`AXIL_ADDR_W-1:0] addr;
    logic [`AXIL_DATA_W-1:0] data;
    logic [`AXIL_STRB_W-1:0] mask;
  } wr_req_t;

endpackage

// File: axil_fifo_consts.svh
// bus and memory sizing macros for the AXI4-Lite to fifo bridge; include wherever storage is sized.
`ifndef AXIL_FIFO_CONSTS_SVH
`define AXIL_FIFO_CONSTS_SVH

// AXI4-Lite data bus width in bits.
`define AXIL_DATA_W 32

// AXI4-Lite address width in bits.
`define AXIL_ADDR_W 32

// one strobe bit per data byte.
`define AXIL_STRB_W 4

// scratch memory depth in words.
`define MEM_WORDS 256

// word index width, log2 of the depth.
`define MEM_IDX_W 8

`endif
